// ==== common/cache_tag_pkg.sv ====
//////////////////////////////
// geometry, vector types and request/response structs
// shared by the cache tag directory blocks
//////////////////////////////

package cache_tag_pkg;

	// directory geometry
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int INDEX_W  = 4;
	localparam int TAG_W    = 8;
	localparam int WAY_W    = 2;

	// random source width used by the top level
	localparam int LFSR_W   = 8;

	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [WAY_W-1:0]    way_t;
	typedef logic [NUM_WAYS-1:0] way_mask_t;
	typedef tag_t [NUM_WAYS-1:0] set_tags_t;
	typedef logic [LFSR_W-1:0]   rand_t;

	// lookup presented with the access strobe
	typedef struct packed {
		index_t index;
		tag_t   tag;
	} lookup_req_t;

	// answer returned one cycle after access
	typedef struct packed {
		logic   hit;
		way_t   way;
		logic   evict;
		tag_t   evict_tag;
	} lookup_resp_t;

	// allocation write back into the tag store
	typedef struct packed {
		logic   we;
		index_t index;
		way_t   way;
		tag_t   tag;
	} fill_t;

endpackage

// ==== source/lfsr_rand.sv ====
//////////////////////////////
// free-running maximal-length LFSR, widths 3 to 16
// feeds random victim choice
//////////////////////////////

`timescale 1ns/1ps

module lfsr_rand
	import cache_tag_pkg::*;
#(
	parameter int width = LFSR_W
)(
	input  logic             clk,
	input  logic             reset_,
	output logic [width-1:0] out
);

	localparam int WIDTH_MIN = 3;
	localparam int WIDTH_MAX = 16;

	// feedback taps per width, bit n-1 set for tap n
	function automatic logic [15:0] tap_mask(input int w);
		case (w)
			3:       return 16'h0006;
			4:       return 16'h000c;
			5:       return 16'h0014;
			6:       return 16'h0030;
			7:       return 16'h0060;
			8:       return 16'h00b8;
			9:       return 16'h0110;
			10:      return 16'h0240;
			11:      return 16'h0500;
			12:      return 16'h0829;
			13:      return 16'h100d;
			14:      return 16'h2015;
			15:      return 16'h6000;
			16:      return 16'hd008;
			default: return 16'h0000;
		endcase
	endfunction

	localparam logic [15:0] TAPS = tap_mask(width);

	if (width < WIDTH_MIN || width > WIDTH_MAX) begin : g_width_check
		$error("lfsr_rand: width %0d outside %0d..%0d", width, WIDTH_MIN, WIDTH_MAX);
	end

	logic [width-1:0] state;
	logic             feedback;

	// xor of the tapped state bits
	assign feedback = ^(state & TAPS[width-1:0]);

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			state <= {{(width-1){1'b0}}, 1'b1};
		end else begin
			// shift toward msb, new bit enters at lsb
			state <= {state[width-2:0], feedback};
		end
	end

	assign out = state;

endmodule

// ==== cache_tag/tag_store.sv ====
//////////////////////////////
// valid and tag arrays with one-cycle set read,
// fill write port, flush and fill-to-read forwarding
//////////////////////////////

`timescale 1ns/1ps

module tag_store
	import cache_tag_pkg::*;
(
	input  logic        clk,
	input  logic        reset_,
	input  logic        access,
	input  lookup_req_t req,
	input  logic        flush,
	input  fill_t       fill,
	output logic        rd_valid,
	output lookup_req_t rd_req,
	output way_mask_t   rd_valid_bits,
	output set_tags_t   rd_tags
);

	way_mask_t valid_q [NUM_SETS];
	set_tags_t tags_q  [NUM_SETS];

	way_mask_t fwd_valid;
	set_tags_t fwd_tags;
	logic      fwd_hit;

	// fill landing on the set being read this cycle
	assign fwd_hit = fill.we && (fill.index == req.index);

	always_comb begin
		fwd_valid = valid_q[req.index];
		fwd_tags  = tags_q[req.index];
		if (fwd_hit) begin
			fwd_valid[fill.way] = 1'b1;
			fwd_tags[fill.way]  = fill.tag;
		end
	end

	// valid bits, flush beats a coincident fill
	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (flush) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (fill.we) begin
			valid_q[fill.index][fill.way] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill.we) begin
			tags_q[fill.index][fill.way] <= fill.tag;
		end
	end

	// response strobe
	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= access;
		end
	end

	// captured set, held until the next access
	always_ff @(posedge clk) begin
		if (access) begin
			rd_req        <= req;
			rd_valid_bits <= fwd_valid;
			rd_tags       <= fwd_tags;
		end
	end

endmodule

// ==== cache_tag/tag_match.sv ====
//////////////////////////////
// tag compare for one set, builds the response
// and the fill request on a miss
//////////////////////////////

`timescale 1ns/1ps

module tag_match
	import cache_tag_pkg::*;
(
	input  logic         rd_valid,
	input  lookup_req_t  rd_req,
	input  way_mask_t    rd_valid_bits,
	input  set_tags_t    rd_tags,
	input  way_t         victim_way,
	input  logic         victim_valid,
	output logic         resp_valid,
	output lookup_resp_t resp,
	output fill_t        fill
);

	way_mask_t match;
	way_t      hit_way;
	logic      hit;

	always_comb begin
		match   = '0;
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			match[w] = rd_valid_bits[w] && (rd_tags[w] == rd_req.tag);
		end
		// at most one way matches, plain encode
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit = |match;

	assign resp_valid     = rd_valid;
	assign resp.hit       = hit;
	assign resp.way       = hit ? hit_way : victim_way;
	assign resp.evict     = !hit && victim_valid;
	assign resp.evict_tag = rd_tags[victim_way];

	// allocate on miss, written at the end of this cycle
	assign fill.we    = rd_valid && !hit;
	assign fill.index = rd_req.index;
	assign fill.way   = victim_way;
	assign fill.tag   = rd_req.tag;

endmodule

// ==== cache_tag/victim_select.sv ====
//////////////////////////////
// fill way choice, lowest invalid way first,
// random way once the set is full
//////////////////////////////

`timescale 1ns/1ps

module victim_select
	import cache_tag_pkg::*;
(
	input  way_mask_t valid_bits,
	input  rand_t     rand_word,
	output way_t      victim_way,
	output logic      victim_valid
);

	way_t free_way;
	logic set_full;

	// scan from the top so the lowest invalid way wins
	always_comb begin
		free_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!valid_bits[w]) begin
				free_way = way_t'(w);
			end
		end
	end

	assign set_full = &valid_bits;

	assign victim_way   = set_full ? rand_word[WAY_W-1:0] : free_way;
	// chosen way only holds a line when the set is full
	assign victim_valid = set_full;

endmodule

// ==== cache_tag/cache_tag_top.sv ====
//////////////////////////////
// cache tag directory top, store, compare,
// victim choice and random source
//////////////////////////////

`timescale 1ns/1ps

module cache_tag_top
	import cache_tag_pkg::*;
(
	input  logic         clk,
	input  logic         reset_,
	input  logic         access,
	input  lookup_req_t  req,
	input  logic         flush,
	output logic         resp_valid,
	output lookup_resp_t resp
);

	rand_t       rand_word;
	fill_t       fill;
	logic        rd_valid;
	lookup_req_t rd_req;
	way_mask_t   rd_valid_bits;
	set_tags_t   rd_tags;
	way_t        victim_way;
	logic        victim_valid;

	lfsr_rand #(
		.width (LFSR_W)
	) lfsr_rand_inst (
		.clk    (clk),
		.reset_ (reset_),
		.out    (rand_word)
	);

	tag_store tag_store_inst (
		.clk           (clk),
		.reset_        (reset_),
		.access        (access),
		.req           (req),
		.flush         (flush),
		.fill          (fill),
		.rd_valid      (rd_valid),
		.rd_req        (rd_req),
		.rd_valid_bits (rd_valid_bits),
		.rd_tags       (rd_tags)
	);

	victim_select victim_select_inst (
		.valid_bits   (rd_valid_bits),
		.rand_word    (rand_word),
		.victim_way   (victim_way),
		.victim_valid (victim_valid)
	);

	tag_match tag_match_inst (
		.rd_valid      (rd_valid),
		.rd_req        (rd_req),
		.rd_valid_bits (rd_valid_bits),
		.rd_tags       (rd_tags),
		.victim_way    (victim_way),
		.victim_valid  (victim_valid),
		.resp_valid    (resp_valid),
		.resp          (resp),
		.fill          (fill)
	);

endmodule

// ==== verification/cache_tag_asserts.sv ====
//////////////////////////////
// timing rules of the tag directory top,
// bound into cache_tag_top
//////////////////////////////

`timescale 1ns/1ps

module cache_tag_asserts
	import cache_tag_pkg::*;
(
	input logic         clk,
	input logic         reset_,
	input logic         access,
	input logic         resp_valid,
	input lookup_resp_t resp
);

	// one response per access, one cycle later
	resp_follows_access: assert property (@(posedge clk) disable iff (!reset_)
		resp_valid == $past(access))
		else $error("resp_valid does not follow access by one cycle");

	// quiet coming out of reset
	resp_idle_in_reset: assert property (@(posedge clk) !reset_ |=> !resp_valid)
		else $error("resp_valid high right after reset");

	resp_hit_no_evict: assert property (@(posedge clk) disable iff (!reset_)
		resp_valid && resp.hit |-> !resp.evict)
		else $error("evict raised on a hit");

endmodule

bind cache_tag_top cache_tag_asserts cache_tag_asserts_inst (
	.clk        (clk),
	.reset_     (reset_),
	.access     (access),
	.resp_valid (resp_valid),
	.resp       (resp)
);

// ==== verification/cache_tag_tb.sv ====
//////////////////////////////
// directed testbench for the cache tag directory
// with a reference model of valid bits and tags
//////////////////////////////

`timescale 1ns/1ps

module cache_tag_tb;
	import cache_tag_pkg::*;

	localparam int RESP_TIMEOUT = 10;

	logic         clk;
	logic         reset_;
	logic         access;
	lookup_req_t  req;
	logic         flush;
	logic         resp_valid;
	lookup_resp_t resp;

	// reference directory contents
	logic model_valid [NUM_SETS][NUM_WAYS];
	tag_t model_tag   [NUM_SETS][NUM_WAYS];

	int           seed = 32'h4dfe;
	way_mask_t    ways_seen;
	lookup_resp_t last;

	cache_tag_top cache_tag_top_inst (
		.clk        (clk),
		.reset_     (reset_),
		.access     (access),
		.req        (req),
		.flush      (flush),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

	always #50 clk = ~clk;

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_way(input string name, input way_t exp, input way_t got);
		if (got !== exp) begin
			fail_now($sformatf("** Error: %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_resp(input lookup_resp_t exp, input lookup_resp_t got);
		if (got.hit !== exp.hit) begin
			fail_now($sformatf("** Error: resp.hit expected %h got %h", exp.hit, got.hit));
		end else if (got.evict !== exp.evict) begin
			fail_now($sformatf("** Error: resp.evict expected %h got %h", exp.evict, got.evict));
		end else if (exp.evict && got.evict_tag !== exp.evict_tag) begin
			fail_now($sformatf("** Error: resp.evict_tag expected %h got %h",
				exp.evict_tag, got.evict_tag));
		end else begin
			check_way("resp.way", exp.way, got.way);
		end
	endtask

	task automatic clear_model();
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
			end
		end
	endtask

	// one access checked against the model, from falling edge to falling edge
	task automatic lookup(input index_t index, input tag_t tag);
		lookup_resp_t exp;
		int           cycles;
		logic         full;
		exp  = '0;
		full = 1'b1;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (!model_valid[index][w]) begin
				full    = 1'b0;
				exp.way = way_t'(w);
			end
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (model_valid[index][w] && model_tag[index][w] == tag) begin
				exp.hit = 1'b1;
				exp.way = way_t'(w);
			end
		end
		access    = 1'b1;
		req.index = index;
		req.tag   = tag;
		@(negedge clk);
		access = 1'b0;
		cycles = 0;
		while (!resp_valid) begin
			if (cycles == RESP_TIMEOUT) begin
				fail_now("timeout waiting for resp_valid after an access");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		last = resp;
		if (!exp.hit && full) begin
			// random victim takes its old tag from the model
			exp.way       = last.way;
			exp.evict     = 1'b1;
			exp.evict_tag = model_tag[index][last.way];
			ways_seen[last.way] = 1'b1;
		end
		check_resp(exp, last);
		if (!exp.hit) begin
			model_valid[index][exp.way] = 1'b1;
			model_tag[index][exp.way]   = tag;
		end
	endtask

	task automatic do_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		clear_model();
	endtask

	task automatic test_fill_order();
		for (int i = 0; i < NUM_WAYS; i++) begin
			lookup(4'd3, tag_t'(8'h10 + i));
		end
		for (int i = 0; i < NUM_WAYS; i++) begin
			lookup(4'd3, tag_t'(8'h10 + i));
		end
	endtask

	task automatic test_random_replace();
		tag_t old_tag;
		for (int i = 0; i < NUM_WAYS; i++) begin
			lookup(4'd9, tag_t'(8'h20 + i));
		end
		ways_seen = '0;
		for (int i = 0; i < 20; i++) begin
			lookup(4'd9, tag_t'(8'h80 + i));
			old_tag = last.evict_tag;
			// evicted tag must miss and evict again
			lookup(4'd9, old_tag);
		end
		if (ways_seen != '1) begin
			fail_now($sformatf("random replacement never chose some ways, seen mask %h",
				ways_seen));
		end
	endtask

	task automatic test_back_to_back();
		// consecutive lookups put access high on consecutive cycles
		lookup(4'd12, 8'h55);
		lookup(4'd12, 8'h55);
	endtask

	task automatic test_flush();
		do_flush();
		for (int i = 0; i < NUM_WAYS; i++) begin
			lookup(4'd3, tag_t'(8'h10 + i));
		end
		lookup(4'd9, 8'h20);
	endtask

	task automatic test_set_isolation();
		logic [31:0] rnd;
		for (int i = 0; i < 100; i++) begin
			rnd = $random(seed);
			// few tags per set so hits and evictions both show up
			lookup(rnd[INDEX_W-1:0], {5'b10100, rnd[10:8]});
		end
	endtask

	initial begin
		clk       = 1'b0;
		reset_    = 1'b0;
		access    = 1'b0;
		req       = '0;
		flush     = 1'b0;
		ways_seen = '0;
		last      = '0;
		clear_model();
		repeat (2) @(negedge clk);
		reset_ = 1'b1;
		test_fill_order();
		test_random_replace();
		test_back_to_back();
		test_flush();
		test_set_isolation();
		$display("No errors");
		$finish;
	end

endmodule

// ==== flist.f ====
common/cache_tag_pkg.sv
source/lfsr_rand.sv
cache_tag/tag_store.sv
cache_tag/tag_match.sv
cache_tag/victim_select.sv
cache_tag/cache_tag_top.sv
verification/cache_tag_asserts.sv
verification/cache_tag_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the cache tag directory

VERILATOR  ?= verilator
TOP        ?= cache_tag_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Errors found
PASS_MSG   ?= No errors
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	-$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
